//--- hdl/dual_issue_pkg.sv
`default_nettype none

package dual_issue_pkg;

    // ------------------------------
    // Widths
    // ------------------------------
    parameter int DATA_W     = 32;
    parameter int INSTR_W    = 32;
    parameter int REG_ADDR_W = 5;   // 32 registers
    parameter int OPCODE_W   = 6;
    parameter int FUNCT_W    = 6;
    parameter int IMM_W      = 16;

    // ------------------------------
    // Opcode and funct codes
    // ------------------------------
    parameter logic [OPCODE_W-1:0] OPC_RTYPE = 6'd0;
    parameter logic [OPCODE_W-1:0] OPC_ADDI  = 6'd8;

    parameter logic [FUNCT_W-1:0] FUNCT_ADD = 6'h20;
    parameter logic [FUNCT_W-1:0] FUNCT_SUB = 6'h22;
    parameter logic [FUNCT_W-1:0] FUNCT_AND = 6'h24;
    parameter logic [FUNCT_W-1:0] FUNCT_OR  = 6'h25;
    parameter logic [FUNCT_W-1:0] FUNCT_XOR = 6'h26;
    parameter logic [FUNCT_W-1:0] FUNCT_SLT = 6'h2a;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT
    } alu_op_e;

    typedef struct packed {
        logic                  reg_write;
        alu_op_e               alu_op;
        logic                  alu_src;     // Immediate as operand b
        logic [REG_ADDR_W-1:0] rs;
        logic [REG_ADDR_W-1:0] rt;
        logic [REG_ADDR_W-1:0] dst;         // rd or rt, already chosen
        logic [DATA_W-1:0]     imm;         // Sign-extended
    } decoded_instr_t;

    typedef struct packed {
        decoded_instr_t first;
        decoded_instr_t second;
        logic           split;              // Second reads first's result
    } issue_pair_t;

endpackage

`default_nettype wire

//--- hdl/pair_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module pair_decoder (
    input  wire logic                               d_clk,
    input  wire logic                               d_rst,
    input  wire logic                               i_valid,
    input  wire logic [dual_issue_pkg::INSTR_W-1:0] i_instr_1,
    input  wire logic [dual_issue_pkg::INSTR_W-1:0] i_instr_2,
    input  wire logic                               i_hold,
    output logic                                    o_push,
    output dual_issue_pkg::issue_pair_t             o_pair
);
    import dual_issue_pkg::*;

    function automatic decoded_instr_t decode(input logic [INSTR_W-1:0] instr);
        decoded_instr_t       d;
        logic [OPCODE_W-1:0]  opcode;
        logic [FUNCT_W-1:0]   funct;
        opcode      = instr[INSTR_W-1 -: OPCODE_W];
        funct       = instr[FUNCT_W-1:0];
        d.rs        = instr[25:21];
        d.rt        = instr[20:16];
        d.dst       = instr[15:11];
        d.imm       = {{(DATA_W-IMM_W){instr[IMM_W-1]}}, instr[IMM_W-1:0]};
        d.alu_src   = 1'b0;
        d.alu_op    = ALU_ADD;
        d.reg_write = 1'b1;
        if (opcode == OPC_ADDI) begin
            d.alu_src = 1'b1;
            d.dst     = instr[20:16];       // I-type writes rt
        end else if (opcode == OPC_RTYPE) begin
            case (funct)
                FUNCT_ADD: d.alu_op = ALU_ADD;
                FUNCT_SUB: d.alu_op = ALU_SUB;
                FUNCT_AND: d.alu_op = ALU_AND;
                FUNCT_OR:  d.alu_op = ALU_OR;
                FUNCT_XOR: d.alu_op = ALU_XOR;
                FUNCT_SLT: d.alu_op = ALU_SLT;
                default:   d.reg_write = 1'b0;
            endcase
        end else begin
            d.reg_write = 1'b0;             // Unsupported opcode
        end
        return d;
    endfunction

    decoded_instr_t dec_1;
    decoded_instr_t dec_2;
    logic           dep;
    logic           accept;

    assign dec_1  = decode(i_instr_1);
    assign dec_2  = decode(i_instr_2);
    assign accept = i_valid && !i_hold;

    // Second reads the register first writes
    assign dep = dec_1.reg_write && (dec_1.dst != '0) &&
                 ((dec_2.rs == dec_1.dst) ||
                  (!dec_2.alu_src && (dec_2.rt == dec_1.dst)));

    always_ff @(posedge d_clk or negedge d_rst) begin
        if (!d_rst) begin
            o_push <= 1'b0;
        end else begin
            o_push <= accept;
        end
    end

    always_ff @(posedge d_clk) begin
        if (accept) begin
            o_pair.first  <= dec_1;
            o_pair.second <= dec_2;
            o_pair.split  <= dep;
        end
    end

endmodule

`default_nettype wire

//--- hdl/issue_queue.sv
`timescale 1ns/1ps
`default_nettype none

module issue_queue #(
    parameter int QUEUE_DEPTH = 4
) (
    input  wire logic                         d_clk,
    input  wire logic                         d_rst,
    input  wire logic                         i_push,
    input  wire dual_issue_pkg::issue_pair_t  i_pair,
    input  wire logic                         i_pop,
    output dual_issue_pkg::issue_pair_t       o_pair,
    output logic                              o_valid,
    output logic                              o_full
);
    import dual_issue_pkg::*;

    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    issue_pair_t       mem [QUEUE_DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;
    logic              do_pop;

    assign do_pop  = i_pop && o_valid;
    assign o_valid = (count != '0);
    assign o_pair  = mem[rd_ptr];
    // One slot kept for the pair still in the decoder register
    assign o_full  = (count >= CNT_W'(QUEUE_DEPTH - 1));

    always_ff @(posedge d_clk or negedge d_rst) begin
        if (!d_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (i_push) wr_ptr <= next_ptr(wr_ptr);
            if (do_pop) rd_ptr <= next_ptr(rd_ptr);
            count <= count + CNT_W'(i_push) - CNT_W'(do_pop);
        end
    end

    always_ff @(posedge d_clk) begin
        if (i_push) mem[wr_ptr] <= i_pair;
    end

endmodule

`default_nettype wire

//--- hdl/alu_lanes.sv
`timescale 1ns/1ps
`default_nettype none

module alu_lanes (
    input  wire logic                                  d_clk,
    input  wire logic                                  d_rst,
    input  wire logic                                  i_valid,
    input  wire dual_issue_pkg::issue_pair_t           i_pair,
    output logic                                       o_pop,
    output logic                                       o_wb_valid_1,
    output logic                                       o_wb_valid_2,
    output logic [dual_issue_pkg::REG_ADDR_W-1:0]      o_wb_addr_1,
    output logic [dual_issue_pkg::REG_ADDR_W-1:0]      o_wb_addr_2,
    output logic [dual_issue_pkg::DATA_W-1:0]          o_wb_data_1,
    output logic [dual_issue_pkg::DATA_W-1:0]          o_wb_data_2
);
    import dual_issue_pkg::*;

    function automatic logic [DATA_W-1:0] alu(input alu_op_e op,
                                              input logic [DATA_W-1:0] a,
                                              input logic [DATA_W-1:0] b);
        logic [DATA_W-1:0] r;
        case (op)
            ALU_SUB: r = a - b;
            ALU_AND: r = a & b;
            ALU_OR:  r = a | b;
            ALU_XOR: r = a ^ b;
            ALU_SLT: r = DATA_W'($signed(a) < $signed(b));
            default: r = a + b;
        endcase
        return r;
    endfunction

    logic [DATA_W-1:0] rf [2**REG_ADDR_W];     // rf[0] is never written

    decoded_instr_t    replay_q;
    logic              pending_q;
    logic              start_split;

    decoded_instr_t    lane_1;
    decoded_instr_t    lane_2;
    logic              act_1;
    logic              act_2;
    logic [DATA_W-1:0] res_1;
    logic [DATA_W-1:0] res_2;
    logic              we_1;
    logic              we_2;

    // ------------------------------
    // Issue select
    // ------------------------------
    always_comb begin
        lane_1 = i_pair.first;
        lane_2 = i_pair.second;
        act_1  = 1'b0;
        act_2  = 1'b0;
        o_pop  = 1'b0;
        if (pending_q) begin
            lane_1 = replay_q;                  // Replayed second, lane 2 idle
            act_1  = 1'b1;
        end else if (i_valid) begin
            act_1  = 1'b1;
            act_2  = !i_pair.split;
            o_pop  = 1'b1;
        end
    end

    assign start_split = !pending_q && i_valid && i_pair.split;

    assign res_1 = alu(lane_1.alu_op, rf[lane_1.rs],
                       lane_1.alu_src ? lane_1.imm : rf[lane_1.rt]);
    assign res_2 = alu(lane_2.alu_op, rf[lane_2.rs],
                       lane_2.alu_src ? lane_2.imm : rf[lane_2.rt]);

    assign we_1 = act_1 && lane_1.reg_write && (lane_1.dst != '0);
    assign we_2 = act_2 && lane_2.reg_write && (lane_2.dst != '0);

    // ------------------------------
    // Register file and writeback
    // ------------------------------
    always_ff @(posedge d_clk or negedge d_rst) begin
        if (!d_rst) begin
            for (int i = 0; i < 2**REG_ADDR_W; i++) begin
                rf[i] <= '0;
            end
            o_wb_valid_1 <= 1'b0;
            o_wb_valid_2 <= 1'b0;
            pending_q    <= 1'b0;
        end else begin
            if (we_1) rf[lane_1.dst] <= res_1;
            if (we_2) rf[lane_2.dst] <= res_2;  // Lane 2 wins on same dst
            o_wb_valid_1 <= we_1;
            o_wb_valid_2 <= we_2;
            pending_q    <= start_split;
        end
    end

    always_ff @(posedge d_clk) begin
        o_wb_addr_1 <= lane_1.dst;
        o_wb_addr_2 <= lane_2.dst;
        o_wb_data_1 <= res_1;
        o_wb_data_2 <= res_2;
        if (start_split) replay_q <= i_pair.second;
    end

endmodule

`default_nettype wire

//--- hdl/dual_issue_core.sv
`timescale 1ns/1ps
`default_nettype none

module dual_issue_core #(
    parameter int QUEUE_DEPTH = 4
) (
    input  wire logic                                 d_clk,
    input  wire logic                                 d_rst,
    input  wire logic                                 i_valid,
    input  wire logic [dual_issue_pkg::INSTR_W-1:0]   i_instr_1,
    input  wire logic [dual_issue_pkg::INSTR_W-1:0]   i_instr_2,
    output logic                                      o_full,
    output logic                                      o_wb_valid_1,
    output logic                                      o_wb_valid_2,
    output logic [dual_issue_pkg::REG_ADDR_W-1:0]     o_wb_addr_1,
    output logic [dual_issue_pkg::REG_ADDR_W-1:0]     o_wb_addr_2,
    output logic [dual_issue_pkg::DATA_W-1:0]         o_wb_data_1,
    output logic [dual_issue_pkg::DATA_W-1:0]         o_wb_data_2
);
    import dual_issue_pkg::*;

    logic        dec_push;
    issue_pair_t dec_pair;
    issue_pair_t q_pair;
    logic        q_valid;
    logic        lane_pop;

    pair_decoder u_decoder (
        .d_clk     (d_clk),
        .d_rst     (d_rst),
        .i_valid   (i_valid),
        .i_instr_1 (i_instr_1),
        .i_instr_2 (i_instr_2),
        .i_hold    (o_full),        // Almost-full back-pressure
        .o_push    (dec_push),
        .o_pair    (dec_pair)
    );

    issue_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_queue (
        .d_clk   (d_clk),
        .d_rst   (d_rst),
        .i_push  (dec_push),
        .i_pair  (dec_pair),
        .i_pop   (lane_pop),
        .o_pair  (q_pair),
        .o_valid (q_valid),
        .o_full  (o_full)
    );

    alu_lanes u_lanes (
        .d_clk        (d_clk),
        .d_rst        (d_rst),
        .i_valid      (q_valid),
        .i_pair       (q_pair),
        .o_pop        (lane_pop),
        .o_wb_valid_1 (o_wb_valid_1),
        .o_wb_valid_2 (o_wb_valid_2),
        .o_wb_addr_1  (o_wb_addr_1),
        .o_wb_addr_2  (o_wb_addr_2),
        .o_wb_data_1  (o_wb_data_1),
        .o_wb_data_2  (o_wb_data_2)
    );

endmodule

`default_nettype wire

//--- tb/wb_checker.sv
`timescale 1ns/1ps
`default_nettype none

module wb_checker #(
    parameter int MAX_ROWS = 64
) (
    input  wire logic                                 d_clk,
    input  wire logic                                 d_rst,
    input  wire logic                                 i_valid,
    input  wire logic [dual_issue_pkg::INSTR_W-1:0]   i_instr_1,
    input  wire logic [dual_issue_pkg::INSTR_W-1:0]   i_instr_2,
    input  wire logic                                 i_full,
    input  wire logic                                 i_wb_valid_1,
    input  wire logic                                 i_wb_valid_2,
    input  wire logic [dual_issue_pkg::REG_ADDR_W-1:0] i_wb_addr_1,
    input  wire logic [dual_issue_pkg::REG_ADDR_W-1:0] i_wb_addr_2,
    input  wire logic [dual_issue_pkg::DATA_W-1:0]    i_wb_data_1,
    input  wire logic [dual_issue_pkg::DATA_W-1:0]    i_wb_data_2,
    output int                                        o_rows_done,
    output int                                        o_rows_passed,
    output int                                        o_rows_failed,
    output int                                        o_stray_errors
);
    import dual_issue_pkg::*;

    // One writeback cycle as the DUT should show it
    typedef struct packed {
        logic                  v1;
        logic [REG_ADDR_W-1:0] a1;
        logic [DATA_W-1:0]     d1;
        logic                  v2;
        logic [REG_ADDR_W-1:0] a2;
        logic [DATA_W-1:0]     d2;
        logic                  chained;     // Must follow the previous beat
        logic [15:0]           row;
    } beat_t;

    logic [DATA_W-1:0] model_rf [2**REG_ADDR_W];
    beat_t             beats [$];
    int                row_left [MAX_ROWS];
    int                row_errs [MAX_ROWS];
    int                accepted;
    int                miss_row;

    // Executes one instruction on the model register file in program order
    task automatic model_instr(input  logic [INSTR_W-1:0]    instr,
                               output logic                  wr,
                               output logic [REG_ADDR_W-1:0] dst,
                               output logic [DATA_W-1:0]     val);
        logic [DATA_W-1:0] a;
        logic [DATA_W-1:0] b;
        logic [DATA_W-1:0] imm;
        a   = model_rf[instr[25:21]];
        b   = model_rf[instr[20:16]];
        imm = {{16{instr[15]}}, instr[15:0]};
        wr  = 1'b1;
        dst = instr[15:11];
        val = '0;
        if (instr[31:26] == OPC_ADDI) begin
            dst = instr[20:16];
            val = a + imm;
        end else if (instr[31:26] == OPC_RTYPE) begin
            case (instr[5:0])
                FUNCT_ADD: val = a + b;
                FUNCT_SUB: val = a - b;
                FUNCT_AND: val = a & b;
                FUNCT_OR:  val = a | b;
                FUNCT_XOR: val = a ^ b;
                FUNCT_SLT: val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                default:   wr  = 1'b0;
            endcase
        end else begin
            wr = 1'b0;
        end
        if (dst == '0) wr = 1'b0;           // r0 is never written
        if (wr) model_rf[dst] = val;
    endtask

    task automatic accept_pair();
        beat_t                 b;
        logic                  w1;
        logic                  w2;
        logic                  split;
        logic [REG_ADDR_W-1:0] d1;
        logic [REG_ADDR_W-1:0] d2;
        logic [DATA_W-1:0]     v1;
        logic [DATA_W-1:0]     v2;
        model_instr(i_instr_1, w1, d1, v1);
        split = w1 && ((i_instr_2[25:21] == d1) ||
                       ((i_instr_2[31:26] == OPC_RTYPE) && (i_instr_2[20:16] == d1)));
        model_instr(i_instr_2, w2, d2, v2);
        row_left[accepted] = 0;
        row_errs[accepted] = 0;
        b     = '0;
        b.row = 16'(accepted);
        if (split) begin
            b.v1 = 1'b1;
            b.a1 = d1;
            b.d1 = v1;
            beats.push_back(b);
            row_left[accepted]++;
            if (w2) begin
                b.a1      = d2;             // Replayed second on lane 1
                b.d1      = v2;
                b.chained = 1'b1;
                beats.push_back(b);
                row_left[accepted]++;
            end
        end else if (w1 || w2) begin
            b.v1 = w1;
            b.a1 = d1;
            b.d1 = v1;
            b.v2 = w2;
            b.a2 = d2;
            b.d2 = v2;
            beats.push_back(b);
            row_left[accepted]++;
        end
        accepted++;
    endtask

    task automatic compare_lane(input int row, input int lane, input logic exp_v,
                                input logic [REG_ADDR_W-1:0] exp_a,
                                input logic [DATA_W-1:0] exp_d, input logic got_v,
                                input logic [REG_ADDR_W-1:0] got_a,
                                input logic [DATA_W-1:0] got_d);
        if (got_v !== exp_v) begin
            $display("Row %0d: lane %0d writeback valid is %b where %b was expected",
                     row, lane, got_v, exp_v);
            row_errs[row]++;
        end else if (exp_v && ((got_a !== exp_a) || (got_d !== exp_d))) begin
            $display("Fail at %0t: row %0d lane %0d wrote r%0d = %h, expected r%0d = %h",
                     $time, row, lane, got_a, got_d, exp_a, exp_d);
            row_errs[row]++;
        end
    endtask

    task automatic check_beat();
        beat_t b;
        if (beats.size() == 0) begin
            $display("Writeback at %0t with no instruction left to retire", $time);
            o_stray_errors++;
        end else begin
            b = beats.pop_front();
            compare_lane(b.row, 1, b.v1, b.a1, b.d1, i_wb_valid_1, i_wb_addr_1, i_wb_data_1);
            compare_lane(b.row, 2, b.v2, b.a2, b.d2, i_wb_valid_2, i_wb_addr_2, i_wb_data_2);
            row_left[b.row]--;
        end
    endtask

    // Rows retire in order once all their beats are seen
    task automatic finish_rows();
        while ((o_rows_done < accepted) && (row_left[o_rows_done] == 0)) begin
            if (row_errs[o_rows_done] == 0) begin
                $display("Row %0d finished: ok", o_rows_done);
                o_rows_passed++;
            end else begin
                $display("Row %0d finished: %0d errors", o_rows_done, row_errs[o_rows_done]);
                o_rows_failed++;
            end
            o_rows_done++;
        end
    endtask

    // Outputs are stable at the falling edge
    always @(negedge d_clk or negedge d_rst) begin
        if (!d_rst) begin
            for (int i = 0; i < 2**REG_ADDR_W; i++) begin
                model_rf[i] = '0;
            end
            beats.delete();
            accepted        = 0;
            o_rows_done     = 0;
            o_rows_passed   = 0;
            o_rows_failed   = 0;
            o_stray_errors  = 0;
        end else begin
            if ((accepted == 0) && (i_wb_valid_1 || i_wb_valid_2 || i_full)) begin
                $display("Output active at %0t before any pair was accepted", $time);
                o_stray_errors++;
            end
            if (i_wb_valid_1 || i_wb_valid_2) begin
                check_beat();
            end else if ((beats.size() > 0) && beats[0].chained) begin
                miss_row = beats[0].row;
                $display("Row %0d: replayed instruction missing from lane 1", miss_row);
                row_errs[miss_row]++;
                row_left[miss_row]--;
                beats.delete(0);
            end
            if (i_valid && !i_full) accept_pair();  // Taken at the next rising edge
            finish_rows();
        end
    end

endmodule

`default_nettype wire

//--- tb/tb_dual_issue.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dual_issue;
    import dual_issue_pkg::*;

    localparam int QUEUE_DEPTH = 4;
    localparam int NUM_ROWS    = 24;
    localparam int BURST_ROW   = 13;        // Back to back from here on

    logic                  d_clk;
    logic                  d_rst;
    logic                  i_valid;
    logic [INSTR_W-1:0]    i_instr_1;
    logic [INSTR_W-1:0]    i_instr_2;
    logic                  o_full;
    logic                  o_wb_valid_1;
    logic                  o_wb_valid_2;
    logic [REG_ADDR_W-1:0] o_wb_addr_1;
    logic [REG_ADDR_W-1:0] o_wb_addr_2;
    logic [DATA_W-1:0]     o_wb_data_1;
    logic [DATA_W-1:0]     o_wb_data_2;

    logic [INSTR_W-1:0]    tbl_instr_1 [NUM_ROWS];
    logic [INSTR_W-1:0]    tbl_instr_2 [NUM_ROWS];
    int                    tbl_gap [NUM_ROWS];
    int                    max_gap;
    integer                seed;
    logic                  full_seen;
    int                    rows_done;
    int                    rows_passed;
    int                    rows_failed;
    int                    stray_errors;
    int                    cycles;
    int                    limit;

    function automatic logic [INSTR_W-1:0] rtype(input logic [FUNCT_W-1:0] funct,
                                                 input int rd, input int rs, input int rt);
        return {OPC_RTYPE, 5'(rs), 5'(rt), 5'(rd), 5'd0, funct};
    endfunction

    function automatic logic [INSTR_W-1:0] addi(input int rt, input int rs, input int imm);
        return {OPC_ADDI, 5'(rs), 5'(rt), 16'(imm)};
    endfunction

    task automatic set_row(input int idx, input logic [INSTR_W-1:0] i1,
                           input logic [INSTR_W-1:0] i2);
        tbl_instr_1[idx] = i1;
        tbl_instr_2[idx] = i2;
        tbl_gap[idx]     = (idx >= BURST_ROW) ? 0 : ($unsigned($random(seed)) % 4);
        if (tbl_gap[idx] > max_gap) max_gap = tbl_gap[idx];
    endtask

    // ------------------------------
    // Stimulus table
    // ------------------------------
    task automatic build_table();
        set_row(0,  addi(1, 0, 100),                addi(2, 0, -7));
        set_row(1,  addi(3, 0, 32'h7fff),           addi(4, 0, -32768));
        set_row(2,  rtype(FUNCT_ADD, 5, 1, 2),      rtype(FUNCT_SUB, 6, 1, 2));
        set_row(3,  rtype(FUNCT_AND, 7, 3, 4),      rtype(FUNCT_OR, 8, 3, 2));
        set_row(4,  rtype(FUNCT_XOR, 9, 1, 3),      rtype(FUNCT_SLT, 10, 2, 1));
        set_row(5,  rtype(FUNCT_SLT, 11, 1, 2),     rtype(FUNCT_SLT, 12, 4, 3));
        set_row(6,  rtype(FUNCT_ADD, 13, 1, 1),     rtype(FUNCT_SUB, 14, 13, 2));
        set_row(7,  addi(15, 0, 5),                 rtype(FUNCT_OR, 16, 3, 15));
        set_row(8,  addi(17, 0, -1),                addi(18, 17, 3));
        set_row(9,  rtype(FUNCT_ADD, 0, 1, 2),      addi(0, 0, 55));
        set_row(10, rtype(FUNCT_ADD, 19, 0, 1),     rtype(FUNCT_OR, 20, 0, 0));
        set_row(11, addi(21, 0, 11),                addi(21, 0, 22));
        set_row(12, rtype(FUNCT_ADD, 22, 21, 0),    rtype(FUNCT_SUB, 23, 21, 1));
        set_row(13, rtype(FUNCT_ADD, 1, 1, 2),      rtype(FUNCT_ADD, 2, 1, 1));
        set_row(14, rtype(FUNCT_SUB, 3, 3, 1),      rtype(FUNCT_XOR, 4, 3, 4));
        set_row(15, addi(5, 5, 1),                  addi(5, 5, 1));
        set_row(16, rtype(FUNCT_AND, 6, 5, 3),      rtype(FUNCT_OR, 7, 6, 1));
        set_row(17, rtype(FUNCT_ADD, 8, 1, 2),      rtype(FUNCT_SUB, 9, 3, 4));
        set_row(18, rtype(FUNCT_SLT, 10, 8, 9),     rtype(FUNCT_ADD, 11, 10, 10));
        set_row(19, addi(12, 12, -100),             rtype(FUNCT_ADD, 13, 12, 12));
        set_row(20, rtype(FUNCT_XOR, 14, 14, 13),   addi(15, 14, 7));
        set_row(21, rtype(FUNCT_OR, 16, 0, 1),      rtype(FUNCT_AND, 17, 2, 3));
        set_row(22, rtype(FUNCT_ADD, 0, 1, 2),      rtype(FUNCT_ADD, 18, 0, 1));
        set_row(23, rtype(FUNCT_SUB, 24, 24, 1),    rtype(FUNCT_SLT, 25, 24, 0));
    endtask

    // Holds the pair until the edge where o_full is low
    task automatic apply_row(input int idx);
        repeat (tbl_gap[idx]) begin
            i_valid <= 1'b0;
            @(posedge d_clk);
        end
        i_valid   <= 1'b1;
        i_instr_1 <= tbl_instr_1[idx];
        i_instr_2 <= tbl_instr_2[idx];
        @(posedge d_clk);
        while (o_full) @(posedge d_clk);
    endtask

    dual_issue_core #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) DUT (
        .d_clk        (d_clk),
        .d_rst        (d_rst),
        .i_valid      (i_valid),
        .i_instr_1    (i_instr_1),
        .i_instr_2    (i_instr_2),
        .o_full       (o_full),
        .o_wb_valid_1 (o_wb_valid_1),
        .o_wb_valid_2 (o_wb_valid_2),
        .o_wb_addr_1  (o_wb_addr_1),
        .o_wb_addr_2  (o_wb_addr_2),
        .o_wb_data_1  (o_wb_data_1),
        .o_wb_data_2  (o_wb_data_2)
    );

    wb_checker #(
        .MAX_ROWS (NUM_ROWS)
    ) u_wb_checker (
        .d_clk          (d_clk),
        .d_rst          (d_rst),
        .i_valid        (i_valid),
        .i_instr_1      (i_instr_1),
        .i_instr_2      (i_instr_2),
        .i_full         (o_full),
        .i_wb_valid_1   (o_wb_valid_1),
        .i_wb_valid_2   (o_wb_valid_2),
        .i_wb_addr_1    (o_wb_addr_1),
        .i_wb_addr_2    (o_wb_addr_2),
        .i_wb_data_1    (o_wb_data_1),
        .i_wb_data_2    (o_wb_data_2),
        .o_rows_done    (rows_done),
        .o_rows_passed  (rows_passed),
        .o_rows_failed  (rows_failed),
        .o_stray_errors (stray_errors)
    );

    initial begin
        d_clk = 1'b0;
        forever #20 d_clk = ~d_clk;
    end

    always @(posedge d_clk or negedge d_rst) begin
        if (!d_rst) begin
            full_seen <= 1'b0;
        end else if (o_full) begin
            full_seen <= 1'b1;
        end
    end

    initial begin
        seed      = 32'h8b2ff6bf;
        max_gap   = 0;
        d_rst     <= 1'b0;
        i_valid   <= 1'b0;
        i_instr_1 <= '0;
        i_instr_2 <= '0;
        build_table();
        repeat (16) @(posedge d_clk);
        d_rst <= 1'b1;
        repeat (3) @(posedge d_clk);
        for (int i = 0; i < NUM_ROWS; i++) begin
            apply_row(i);
        end
        i_valid <= 1'b0;
        while (rows_done < NUM_ROWS) @(posedge d_clk);
        repeat (5) @(posedge d_clk);            // Catch late stray writebacks
        if (!full_seen) begin
            $display("o_full never rose although pairs arrived back to back");
        end
        $display("Rows passed: %0d, rows failed: %0d, other errors: %0d",
                 rows_passed, rows_failed, stray_errors);
        if (full_seen && (rows_failed == 0) && (stray_errors == 0)) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    initial begin
        cycles = 0;
        @(posedge d_rst);
        limit = NUM_ROWS * (QUEUE_DEPTH + 4 + max_gap) + 50;
        while (cycles < limit) begin
            @(posedge d_clk);
            cycles++;
        end
        $display("Timeout after %0d cycles with %0d of %0d rows finished",
                 cycles, rows_done, NUM_ROWS);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
hdl/dual_issue_pkg.sv
hdl/pair_decoder.sv
hdl/issue_queue.sv
hdl/alu_lanes.sv
hdl/dual_issue_core.sv
tb/wb_checker.sv
tb/tb_dual_issue.sv

//--- Bender.yml
package:
  name: dual_issue_core

sources:
  - files:
      - hdl/dual_issue_pkg.sv
      - hdl/pair_decoder.sv
      - hdl/issue_queue.sv
      - hdl/alu_lanes.sv
      - hdl/dual_issue_core.sv
  - target: test
    files:
      - tb/wb_checker.sv
      - tb/tb_dual_issue.sv
